// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SoC testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module ara_soc_tb -f sim.f; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vara_soc_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" <<< "$output"; then
  exit 0
else
  exit 1
fi

// File: sim.f
source/soc_pkg.sv
source/apb_if.sv
source/soc_addr_decoder.sv
source/soc_dram.sv
source/soc_uart_bridge.sv
source/soc_ctrl_regs.sv
source/ara_soc.sv
tb/tb_clock_gen.sv
tb/ara_soc_properties.sv
tb/ara_soc_tb.sv

// File: source/apb_if.sv
/*
  APB bus between the address decoder and one region
*/

`default_nettype none

interface apb_if (
  input logic clk_i
);

  logic           psel;
  logic           penable;
  logic           pwrite;
  soc_pkg::addr_t paddr;
  soc_pkg::data_t pwdata;
  soc_pkg::data_t prdata;
  logic           pready;
  logic           pslverr;

  modport requester (
    input  clk_i, prdata, pready, pslverr,
    output psel, penable, pwrite, paddr, pwdata
  );

  modport completer (
    input  clk_i, psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface : apb_if

`default_nettype wire

// File: source/ara_soc.sv
/*
  SoC peripheral top level
  APB requester port decoded onto DRAM, UART bridge and control registers
*/

`default_nettype none

module ara_soc #(
  parameter int unsigned DramWords = 1024
) (
  input  logic            clk_i,
  input  logic            reset_i,
  // Upstream APB
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  soc_pkg::addr_t  paddr_i,
  input  soc_pkg::data_t  pwdata_i,
  output soc_pkg::data_t  prdata_o,
  output logic            pready_o,
  output logic            pslverr_o,
  // System control
  output soc_pkg::data_t  exit_o,
  output soc_pkg::data_t  hw_cnt_en_o,
  // External UART APB
  output logic            uart_penable_o,
  output logic            uart_pwrite_o,
  output soc_pkg::addr_t  uart_paddr_o,
  output logic            uart_psel_o,
  output soc_pkg::data_t  uart_pwdata_o,
  input  soc_pkg::data_t  uart_prdata_i,
  input  logic            uart_pready_i,
  input  logic            uart_pslverr_i
);

  apb_if dram_bus (.clk_i(clk_i));
  apb_if uart_bus (.clk_i(clk_i));
  apb_if ctrl_bus (.clk_i(clk_i));

  ////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////

  soc_addr_decoder #(
    .DramWords (DramWords)
  ) u_addr_decoder (
    .clk_i     (clk_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .dram_o    (dram_bus.requester),
    .uart_o    (uart_bus.requester),
    .ctrl_o    (ctrl_bus.requester)
  );

  ////////////////////////////////////////
  // Regions
  ////////////////////////////////////////

  soc_dram #(
    .DramWords (DramWords)
  ) u_dram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus_i   (dram_bus.completer)
  );

  soc_uart_bridge u_uart_bridge (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .bus_i          (uart_bus.completer),
    .uart_prdata_i  (uart_prdata_i),
    .uart_pready_i  (uart_pready_i),
    .uart_pslverr_i (uart_pslverr_i),
    .uart_psel_o    (uart_psel_o),
    .uart_penable_o (uart_penable_o),
    .uart_pwrite_o  (uart_pwrite_o),
    .uart_paddr_o   (uart_paddr_o),
    .uart_pwdata_o  (uart_pwdata_o)
  );

  soc_ctrl_regs #(
    .DramWords (DramWords)
  ) u_ctrl_regs (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .bus_i       (ctrl_bus.completer),
    .exit_o      (exit_o),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

endmodule : ara_soc

`default_nettype wire

// File: source/soc_addr_decoder.sv
/*
  Address decoder
  Routes an upstream APB transfer to DRAM, UART or CTRL with a region offset,
  muxes the response back and fails transfers to unmapped addresses
*/

`default_nettype none

module soc_addr_decoder #(
  parameter int unsigned DramWords = 1024
) (
  input  logic            clk_i,
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  soc_pkg::addr_t  paddr_i,
  input  soc_pkg::data_t  pwdata_i,
  output soc_pkg::data_t  prdata_o,
  output logic            pready_o,
  output logic            pslverr_o,
  apb_if.requester        dram_o,
  apb_if.requester        uart_o,
  apb_if.requester        ctrl_o
);

  localparam soc_pkg::addr_t DramLength = soc_pkg::addr_t'(DramWords * 4);

  soc_pkg::addr_t   dram_off;
  soc_pkg::addr_t   uart_off;
  soc_pkg::addr_t   ctrl_off;
  soc_pkg::region_e region_d;
  soc_pkg::region_e region_q;
  soc_pkg::region_e region;
  logic             access;

  // Offsets wrap for addresses below a base, so one compare per window
  assign dram_off = paddr_i - soc_pkg::DramBase;
  assign uart_off = paddr_i - soc_pkg::UartBase;
  assign ctrl_off = paddr_i - soc_pkg::CtrlBase;

  always_comb begin
    if (dram_off < DramLength) begin
      region_d = soc_pkg::REGION_DRAM;
    end else if (uart_off < soc_pkg::PeriphLength) begin
      region_d = soc_pkg::REGION_UART;
    end else if (ctrl_off < soc_pkg::PeriphLength) begin
      region_d = soc_pkg::REGION_CTRL;
    end else begin
      region_d = soc_pkg::REGION_NONE;
    end
  end

  // Region held from the setup phase, keeps the compare off the response path
  always_ff @(posedge clk_i) begin
    if (psel_i && !penable_i) begin
      region_q <= region_d;
    end
  end

  assign region = penable_i ? region_q : region_d;
  assign access = psel_i && penable_i;

  ////////////////////////////////////////
  // Request fan-out
  ////////////////////////////////////////

  assign dram_o.psel    = psel_i && (region == soc_pkg::REGION_DRAM);
  assign dram_o.penable = penable_i;
  assign dram_o.pwrite  = pwrite_i;
  assign dram_o.paddr   = dram_off;
  assign dram_o.pwdata  = pwdata_i;

  assign uart_o.psel    = psel_i && (region == soc_pkg::REGION_UART);
  assign uart_o.penable = penable_i;
  assign uart_o.pwrite  = pwrite_i;
  assign uart_o.paddr   = uart_off;
  assign uart_o.pwdata  = pwdata_i;

  assign ctrl_o.psel    = psel_i && (region == soc_pkg::REGION_CTRL);
  assign ctrl_o.penable = penable_i;
  assign ctrl_o.pwrite  = pwrite_i;
  assign ctrl_o.paddr   = ctrl_off;
  assign ctrl_o.pwdata  = pwdata_i;

  ////////////////////////////////////////
  // Response mux
  ////////////////////////////////////////

  always_comb begin
    prdata_o  = '0;
    pready_o  = 1'b0;
    pslverr_o = 1'b0;
    case (region)
      soc_pkg::REGION_DRAM: begin
        prdata_o  = dram_o.prdata;
        pready_o  = access && dram_o.pready;
        pslverr_o = dram_o.pslverr;
      end
      soc_pkg::REGION_UART: begin
        prdata_o  = uart_o.prdata;
        pready_o  = access && uart_o.pready;
        pslverr_o = uart_o.pslverr;
      end
      soc_pkg::REGION_CTRL: begin
        prdata_o  = ctrl_o.prdata;
        pready_o  = access && ctrl_o.pready;
        pslverr_o = ctrl_o.pslverr;
      end
      default: begin
        // Unmapped, answered here with zero data
        pready_o  = access;
        pslverr_o = access;
      end
    endcase
  end

endmodule : soc_addr_decoder

`default_nettype wire

// File: source/soc_ctrl_regs.sv
/*
  Control registers
  Exit code and counter enable, plus read-only DRAM base and length
*/

`default_nettype none

module soc_ctrl_regs #(
  parameter int unsigned DramWords = 1024
) (
  input  logic            clk_i,
  input  logic            reset_i,
  apb_if.completer        bus_i,
  output soc_pkg::data_t  exit_o,
  output soc_pkg::data_t  hw_cnt_en_o
);

  localparam soc_pkg::data_t DramLength = soc_pkg::data_t'(DramWords * 4);

  logic           access;
  logic           err;
  logic           exit_we;
  logic           cnt_en_we;
  soc_pkg::data_t rdata;

  assign access = bus_i.psel && bus_i.penable;

  ////////////////////////////////////////
  // Register decode
  ////////////////////////////////////////

  always_comb begin
    rdata     = '0;
    err       = 1'b0;
    exit_we   = 1'b0;
    cnt_en_we = 1'b0;
    case (bus_i.paddr[11:0])
      soc_pkg::CtrlExitOffset: begin
        rdata   = exit_o;
        exit_we = access && bus_i.pwrite;
      end
      soc_pkg::CtrlHwCntEnOffset: begin
        rdata     = hw_cnt_en_o;
        cnt_en_we = access && bus_i.pwrite;
      end
      soc_pkg::CtrlDramBaseOffset: begin
        rdata = soc_pkg::DramBase;
        err   = bus_i.pwrite;
      end
      soc_pkg::CtrlDramLengthOffset: begin
        rdata = DramLength;
        err   = bus_i.pwrite;
      end
      default: err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_o      <= '0;
      hw_cnt_en_o <= '0;
    end else begin
      if (exit_we) begin
        exit_o <= bus_i.pwdata;
      end
      if (cnt_en_we) begin
        hw_cnt_en_o <= bus_i.pwdata;
      end
    end
  end

  // No wait states
  assign bus_i.pready  = access;
  assign bus_i.pslverr = access && err;
  assign bus_i.prdata  = rdata;

endmodule : soc_ctrl_regs

`default_nettype wire

// File: source/soc_dram.sv
/*
  DRAM region
  Word memory behind APB with one wait state on every access
*/

`default_nettype none

module soc_dram #(
  parameter int unsigned DramWords = 1024
) (
  input  logic      clk_i,
  input  logic      reset_i,
  apb_if.completer  bus_i
);

  localparam int unsigned IdxWidth = $clog2(DramWords);

  soc_pkg::data_t        mem_q [DramWords];
  soc_pkg::data_t        rdata_q;
  logic                  wait_q;
  logic                  access;
  logic [IdxWidth-1:0]   word_idx;

  assign access   = bus_i.psel && bus_i.penable;
  assign word_idx = bus_i.paddr[IdxWidth+1:2];

  ////////////////////////////////////////
  // Wait state
  ////////////////////////////////////////

  // Set in the first access cycle, cleared when the transfer completes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access && !wait_q;
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (access && wait_q && bus_i.pwrite) begin
      mem_q[word_idx] <= bus_i.pwdata;
    end
  end

  // Synchronous read during the wait cycle
  always_ff @(posedge clk_i) begin
    if (access && !wait_q) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  assign bus_i.prdata  = rdata_q;
  assign bus_i.pready  = access && wait_q;
  assign bus_i.pslverr = 1'b0;

endmodule : soc_dram

`default_nettype wire

// File: source/soc_pkg.sv
/*
  SoC package
  Bus widths, memory map, region codes and control register offsets
*/

`default_nettype none

package soc_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  ////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////

  // Target of a transfer
  typedef enum logic [1:0] {
    REGION_DRAM = 2'd0,
    REGION_UART = 2'd1,
    REGION_CTRL = 2'd2,
    REGION_NONE = 2'd3
  } region_e;

  localparam addr_t DramBase = 32'h8000_0000;
  localparam addr_t UartBase = 32'h4000_0000;
  localparam addr_t CtrlBase = 32'h5000_0000;

  // Same window size for both peripherals
  localparam addr_t PeriphLength = 32'h1000;

  ////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////

  localparam logic [11:0] CtrlExitOffset       = 12'h000;
  localparam logic [11:0] CtrlHwCntEnOffset    = 12'h004;
  localparam logic [11:0] CtrlDramBaseOffset   = 12'h008;
  localparam logic [11:0] CtrlDramLengthOffset = 12'h00C;

endpackage : soc_pkg

`default_nettype wire

// File: source/soc_uart_bridge.sv
/*
  UART bridge
  Replays each upstream transfer as a full APB transfer on the external UART port
*/

`default_nettype none

module soc_uart_bridge (
  input  logic            clk_i,
  input  logic            reset_i,
  apb_if.completer        bus_i,
  input  soc_pkg::data_t  uart_prdata_i,
  input  logic            uart_pready_i,
  input  logic            uart_pslverr_i,
  output logic            uart_psel_o,
  output logic            uart_penable_o,
  output logic            uart_pwrite_o,
  output soc_pkg::addr_t  uart_paddr_o,
  output soc_pkg::data_t  uart_pwdata_o
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    RESPOND
  } state_e;

  state_e         state_q;
  state_e         state_d;
  soc_pkg::data_t prdata_q;
  logic           pslverr_q;
  logic           access;

  assign access = bus_i.psel && bus_i.penable;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (access) state_d = SETUP;
      SETUP:   state_d = ACCESS;
      ACCESS:  if (uart_pready_i) state_d = RESPOND;
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request captured once, held for the whole external transfer
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && access) begin
      uart_pwrite_o <= bus_i.pwrite;
      uart_paddr_o  <= bus_i.paddr;
      uart_pwdata_o <= bus_i.pwdata;
    end
    if (state_q == ACCESS && uart_pready_i) begin
      prdata_q  <= uart_prdata_i;
      pslverr_q <= uart_pslverr_i;
    end
  end

  assign uart_psel_o    = (state_q == SETUP) || (state_q == ACCESS);
  assign uart_penable_o = (state_q == ACCESS);

  assign bus_i.pready  = (state_q == RESPOND);
  assign bus_i.prdata  = prdata_q;
  assign bus_i.pslverr = pslverr_q;

endmodule : soc_uart_bridge

`default_nettype wire

// File: tb/ara_soc_golden.txt
# name op(W/R) addr(hex) data(hex: write data, or expected read data) exp_pslverr
# DRAM is 1024 words, so the last word is at 80000ffc
dram_wr_first      W 80000000 11112222 0
dram_wr_second     W 80000004 a5a5a5a5 0
dram_wr_mid        W 80000800 0badf00d 0
dram_wr_last       W 80000ffc deadbeef 0
dram_rd_first      R 80000000 11112222 0
dram_rd_second     R 80000004 a5a5a5a5 0
dram_rd_mid        R 80000800 0badf00d 0
dram_rd_last       R 80000ffc deadbeef 0
ctrl_wr_exit       W 50000000 00000007 0
ctrl_wr_cnt_en     W 50000004 00000001 0
ctrl_rd_exit       R 50000000 00000007 0
ctrl_rd_cnt_en     R 50000004 00000001 0
ctrl_rd_dram_base  R 50000008 80000000 0
ctrl_rd_dram_len   R 5000000c 00001000 0
ctrl_wr_dram_base  W 50000008 12345678 1
ctrl_wr_dram_len   W 5000000c 00000010 1
ctrl_wr_unused     W 50000010 000000ff 1
ctrl_rd_unused     R 50000ff0 00000000 1
ctrl_rd_exit_kept  R 50000000 00000007 0
uart_wr_ctrl       W 40000004 000000c3 0
uart_wr_data       W 40000000 00000041 0
uart_rd_status     R 40000014 5a5a0014 0
uart_rd_data       R 40000000 5a5a0000 0
uart_wr_err        W 40000800 00000055 1
uart_rd_err        R 40000ffc 5a5a0ffc 1
uart_rd_err_low    R 40000800 5a5a0800 1
unmapped_wr        W 10000000 cafef00d 1
unmapped_rd        R 10000000 00000000 1
unmapped_rd_high   R ffff0000 00000000 1
unmapped_dram_end  R 80001000 00000000 1
dram_rd_after      R 80000ffc deadbeef 0

// File: tb/ara_soc_properties.sv
/*
  Concurrent checks on the SoC top-level ports
  Bound into every ara_soc instance
*/

`default_nettype none

module ara_soc_properties (
  input logic           clk_i,
  input logic           reset_i,
  input logic           psel_i,
  input logic           penable_i,
  input logic           pready_i,
  input soc_pkg::data_t exit_i,
  input logic           uart_psel_i,
  input logic           uart_penable_i,
  input logic           uart_pready_i,
  input soc_pkg::addr_t uart_paddr_i,
  input soc_pkg::data_t uart_pwdata_i
);

  a_uart_penable_psel: assert property (@(posedge clk_i) disable iff (reset_i)
    uart_penable_i |-> uart_psel_i)
    else $error("uart_penable_o is high while uart_psel_o is low");

  a_pready_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
    pready_i |-> (psel_i && penable_i))
    else $error("pready_o is high outside an upstream access phase");

  // External request held until the UART completes
  a_uart_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (uart_psel_i && !uart_pready_i) |=> ($stable(uart_paddr_i) && $stable(uart_pwdata_i)))
    else $error("UART address or write data changed during a transfer");

  a_exit_reset: assert property (@(posedge clk_i)
    reset_i |=> (exit_i == '0))
    else $error("exit_o is not zero after reset");

endmodule : ara_soc_properties

bind ara_soc ara_soc_properties u_properties (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .psel_i         (psel_i),
  .penable_i      (penable_i),
  .pready_i       (pready_o),
  .exit_i         (exit_o),
  .uart_psel_i    (uart_psel_o),
  .uart_penable_i (uart_penable_o),
  .uart_pready_i  (uart_pready_i),
  .uart_paddr_i   (uart_paddr_o),
  .uart_pwdata_i  (uart_pwdata_o)
);

`default_nettype wire

// File: tb/ara_soc_tb.sv
/*
  Testbench for the SoC peripheral top level
  Replays the golden transfer list upstream and models the external UART
*/

`default_nettype none

module ara_soc_tb;

  localparam int unsigned ClkPeriod   = 4;
  localparam int unsigned ResetCycles = 16;
  localparam logic [31:0] LcgSeed     = 32'h9c0d_a344;

  logic           clk_i;
  logic           reset_i;
  logic           psel_i;
  logic           penable_i;
  logic           pwrite_i;
  soc_pkg::addr_t paddr_i;
  soc_pkg::data_t pwdata_i;
  soc_pkg::data_t prdata_o;
  logic           pready_o;
  logic           pslverr_o;
  soc_pkg::data_t exit_o;
  soc_pkg::data_t hw_cnt_en_o;
  logic           uart_penable_o;
  logic           uart_pwrite_o;
  soc_pkg::addr_t uart_paddr_o;
  logic           uart_psel_o;
  soc_pkg::data_t uart_pwdata_o;
  soc_pkg::data_t uart_prdata_i;
  logic           uart_pready_i;
  logic           uart_pslverr_i;

  // Golden transfer list
  string          name_q [$];
  bit             write_q [$];
  soc_pkg::addr_t addr_q [$];
  soc_pkg::data_t data_q [$];
  bit             err_q [$];

  int unsigned    error_count = 0;
  int unsigned    done_count  = 0;
  int unsigned    cycle_count = 0;
  int unsigned    cycle_limit = 0;
  bit             timed_out   = 1'b0;
  bit             verdict_done = 1'b0;

  // UART model state
  logic [31:0]    lcg_state;
  logic [1:0]     waits_left;
  logic           uart_last_write;
  soc_pkg::addr_t uart_last_addr;
  soc_pkg::data_t uart_last_data;

  tb_clock_gen #(
    .Period      (ClkPeriod),
    .ResetCycles (ResetCycles)
  ) u_clock_gen (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  ara_soc u_ara_soc (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .exit_o         (exit_o),
    .hw_cnt_en_o    (hw_cnt_en_o),
    .uart_penable_o (uart_penable_o),
    .uart_pwrite_o  (uart_pwrite_o),
    .uart_paddr_o   (uart_paddr_o),
    .uart_psel_o    (uart_psel_o),
    .uart_pwdata_o  (uart_pwdata_o),
    .uart_prdata_i  (uart_prdata_i),
    .uart_pready_i  (uart_pready_i),
    .uart_pslverr_i (uart_pslverr_i)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////
  // UART completer model
  ////////////////////////////////////////

  initial begin
    uart_prdata_i   = '0;
    uart_pready_i   = 1'b0;
    uart_pslverr_i  = 1'b0;
    lcg_state       = LcgSeed;
    waits_left      = 2'd0;
    uart_last_write = 1'b0;
    uart_last_addr  = '0;
    uart_last_data  = '0;
    forever begin
      @(negedge clk_i);
      if (uart_psel_o === 1'b1 && uart_penable_o === 1'b1 && !uart_pready_i) begin
        if (waits_left == 2'd0) begin
          uart_pready_i   = 1'b1;
          uart_prdata_i   = uart_paddr_o ^ 32'h5a5a_0000;
          uart_pslverr_i  = (uart_paddr_o >= 32'h0000_0800);
          uart_last_write = uart_pwrite_o;
          if (uart_pwrite_o) begin
            uart_last_addr = uart_paddr_o;
            uart_last_data = uart_pwdata_o;
          end
        end else begin
          waits_left = waits_left - 2'd1;
        end
      end else begin
        uart_pready_i  = 1'b0;
        uart_pslverr_i = 1'b0;
        // Wait count drawn in the setup phase
        if (uart_psel_o === 1'b1 && uart_penable_o === 1'b0) begin
          lcg_state  = lcg_next(lcg_state);
          waits_left = lcg_state[31:30];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Tasks
  ////////////////////////////////////////

  task automatic read_golden();
    int    fd;
    int    code;
    int    exp_err;
    string line;
    string name;
    string op;
    logic [31:0] addr;
    logic [31:0] data;
    fd = $fopen("tb/ara_soc_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden transfer list tb/ara_soc_golden.txt");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 0 && line[0] != "#") begin
          code = $sscanf(line, "%s %s %h %h %d", name, op, addr, data, exp_err);
          if (code == 5) begin
            name_q.push_back(name);
            write_q.push_back(op == "W");
            addr_q.push_back(addr);
            data_q.push_back(data);
            err_q.push_back(exp_err != 0);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_word(input string test, input string what,
                            input soc_pkg::data_t expected, input soc_pkg::data_t actual);
    assert (actual === expected) else begin
      $display("Fail %s: %s expected %h actual %h", test, what, expected, actual);
      error_count++;
    end
  endtask

  // Setup cycle, then access until the DUT completes
  task automatic apb_transfer(input bit write, input soc_pkg::addr_t addr,
                              input soc_pkg::data_t wdata,
                              output soc_pkg::data_t rdata, output logic err);
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    #(ClkPeriod / 4);
    while (pready_o !== 1'b1) begin
      @(negedge clk_i);
      #(ClkPeriod / 4);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic run_all();
    soc_pkg::data_t rdata;
    logic           err;
    soc_pkg::data_t exp_exit;
    soc_pkg::data_t exp_cnt_en;
    exp_exit   = '0;
    exp_cnt_en = '0;
    @(negedge clk_i);
    while (reset_i !== 1'b0) @(negedge clk_i);
    check_word("reset_idle", "exit_o", '0, exit_o);
    check_word("reset_idle", "hw_cnt_en_o", '0, hw_cnt_en_o);
    check_word("reset_idle", "uart_psel_o", '0, {31'b0, uart_psel_o});
    for (int i = 0; i < name_q.size(); i++) begin
      apb_transfer(write_q[i], addr_q[i], data_q[i], rdata, err);
      check_word(name_q[i], "pslverr", {31'b0, err_q[i]}, {31'b0, err});
      if (!write_q[i]) begin
        check_word(name_q[i], "prdata", data_q[i], rdata);
      end
      if (write_q[i] && !err_q[i] && addr_q[i] == 32'h5000_0000) begin
        exp_exit = data_q[i];
      end
      if (write_q[i] && !err_q[i] && addr_q[i] == 32'h5000_0004) begin
        exp_cnt_en = data_q[i];
      end
      check_word(name_q[i], "exit_o", exp_exit, exit_o);
      check_word(name_q[i], "hw_cnt_en_o", exp_cnt_en, hw_cnt_en_o);
      // External UART sees the direction, the offset and the data
      if (addr_q[i][31:12] == 20'h40000) begin
        check_word(name_q[i], "uart_pwrite", {31'b0, write_q[i]},
                   {31'b0, uart_last_write});
        if (write_q[i]) begin
          check_word(name_q[i], "uart_paddr", addr_q[i] - 32'h4000_0000, uart_last_addr);
          check_word(name_q[i], "uart_pwdata", data_q[i], uart_last_data);
        end
      end
      done_count++;
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    read_golden();
    cycle_limit = ResetCycles + 12 * name_q.size() + 100;
    fork
      run_all();
      begin
        while (cycle_count < cycle_limit) begin
          @(posedge clk_i);
          cycle_count++;
        end
        timed_out = 1'b1;
      end
    join_any
    if (timed_out) begin
      $display("Timeout after %0d cycles, a transfer did not complete", cycle_limit);
    end
    $display("%0d errors, %0d of %0d transfers done", error_count, done_count,
             name_q.size());
    verdict_done = 1'b1;
    if (timed_out || error_count != 0) begin
      $display("Test FAILED");
    end else begin
      $display("Test OK");
    end
    $finish;
  end

  // Run stopped early by a failing bound assertion
  final begin
    if (!verdict_done) begin
      $display("Test FAILED");
    end
  end

endmodule : ara_soc_tb

`default_nettype wire

// File: tb/tb_clock_gen.sv
/*
  Testbench clock and reset
  Free-running clock, reset held high for a fixed number of cycles
*/

`default_nettype none

module tb_clock_gen #(
  parameter int unsigned Period      = 4,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule : tb_clock_gen

`default_nettype wire
